// ==== build.f ====
+incdir+verif
src/ifu_pkg.sv
src/axil_rd_if.sv
src/axil_wr_if.sv
src/axil_inst_sram.sv
src/ifu_fetch.sv
src/fetch_queue.sv
src/inst_predecode.sv
src/ifu_top.sv
verif/tb_ifu_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_ifu_top -f build.f -o sim_ifu
./obj_dir/sim_ifu > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
  exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

// ==== src/axil_inst_sram.sv ====
// AXI-lite slave instruction memory with a two-state read FSM and strobed writes
`timescale 1ns/1ps

module axil_inst_sram (
  input  logic      i_aclk,
  input  logic      i_rst_n,
  axil_rd_if.slave  rd,
  axil_wr_if.slave  wr
);

  logic [ifu_pkg::DATA_WIDTH-1:0]    mem [ifu_pkg::MEM_WORDS];

  ifu_pkg::rd_state_t                rd_state_q;
  logic [ifu_pkg::DATA_WIDTH-1:0]    rdata_q;
  logic [ifu_pkg::MEM_IDX_WIDTH-1:0] rd_idx;
  logic [ifu_pkg::MEM_IDX_WIDTH-1:0] wr_idx;
  logic                              ar_fire;
  logic                              r_fire;
  logic                              wr_go;
  logic                              bvalid_q;

  // --------------------------------------------------------------------------
  // Read side
  // --------------------------------------------------------------------------
  assign ar_fire = rd.arvalid & rd.arready;
  assign r_fire  = rd.rvalid & rd.rready;

  // Addresses wrap on the index bits
  assign rd_idx = rd.araddr[ifu_pkg::MEM_IDX_LSB +: ifu_pkg::MEM_IDX_WIDTH];

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_state_q <= ifu_pkg::RD_IDLE;
    end else begin
      case (rd_state_q)
        ifu_pkg::RD_IDLE: begin
          if (ar_fire) begin
            rd_state_q <= ifu_pkg::RD_READ;
          end
        end
        ifu_pkg::RD_READ: begin
          if (r_fire) begin
            rd_state_q <= ifu_pkg::RD_IDLE;
          end
        end
        default: rd_state_q <= ifu_pkg::RD_IDLE;
      endcase
    end
  end

  // Data captured at AR time, held through any R back-pressure
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      rdata_q <= mem[rd_idx];
    end
  end

  assign rd.arready = (rd_state_q == ifu_pkg::RD_IDLE);
  assign rd.rvalid  = (rd_state_q == ifu_pkg::RD_READ);
  assign rd.rdata   = rdata_q;
  assign rd.rresp   = ifu_pkg::RESP_OKAY;

  // --------------------------------------------------------------------------
  // Write side
  // --------------------------------------------------------------------------
  // Accept address and data together, only with no response pending
  assign wr_go  = wr.awvalid & wr.wvalid & ~bvalid_q;
  assign wr_idx = wr.awaddr[ifu_pkg::MEM_IDX_LSB +: ifu_pkg::MEM_IDX_WIDTH];

  always_ff @(posedge i_aclk) begin
    if (wr_go) begin
      for (int b = 0; b < ifu_pkg::STRB_WIDTH; b++) begin
        if (wr.wstrb[b]) begin
          mem[wr_idx][8*b +: 8] <= wr.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      bvalid_q <= 1'b0;
    end else if (wr_go) begin
      bvalid_q <= 1'b1;
    end else if (wr.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  assign wr.awready = wr_go;
  assign wr.wready  = wr_go;
  assign wr.bvalid  = bvalid_q;
  assign wr.bresp   = ifu_pkg::RESP_OKAY;

endmodule

// ==== src/axil_rd_if.sv ====
// AXI-lite read address and read data channels with master and slave modports
`timescale 1ns/1ps

interface axil_rd_if;

  // Read address channel
  logic                             arvalid;
  logic                             arready;
  logic [ifu_pkg::ADDR_WIDTH-1:0]   araddr;
  logic [ifu_pkg::PROT_WIDTH-1:0]   arprot;

  // Read data channel
  logic                             rvalid;
  logic                             rready;
  logic [ifu_pkg::DATA_WIDTH-1:0]   rdata;
  logic [ifu_pkg::RESP_WIDTH-1:0]   rresp;

  modport master (
    output arvalid, araddr, arprot, rready,
    input  arready, rvalid, rdata, rresp
  );

  modport slave (
    input  arvalid, araddr, arprot, rready,
    output arready, rvalid, rdata, rresp
  );

endinterface

// ==== src/axil_wr_if.sv ====
// AXI-lite write address, write data and write response channels with modports
`timescale 1ns/1ps

interface axil_wr_if;

  // Write address channel
  logic                             awvalid;
  logic                             awready;
  logic [ifu_pkg::ADDR_WIDTH-1:0]   awaddr;
  logic [ifu_pkg::PROT_WIDTH-1:0]   awprot;

  // Write data channel
  logic                             wvalid;
  logic                             wready;
  logic [ifu_pkg::DATA_WIDTH-1:0]   wdata;
  logic [ifu_pkg::STRB_WIDTH-1:0]   wstrb;

  // Write response channel
  logic                             bvalid;
  logic                             bready;
  logic [ifu_pkg::RESP_WIDTH-1:0]   bresp;

  modport master (
    output awvalid, awaddr, awprot, wvalid, wdata, wstrb, bready,
    input  awready, wready, bvalid, bresp
  );

  modport slave (
    input  awvalid, awaddr, awprot, wvalid, wdata, wstrb, bready,
    output awready, wready, bvalid, bresp
  );

endinterface

// ==== src/fetch_queue.sv ====
// Circular FIFO of PC and instruction pairs with single-cycle flush
`timescale 1ns/1ps

module fetch_queue (
  input  logic               i_aclk,
  input  logic               i_rst_n,
  input  logic               i_flush,
  input  logic               i_push_valid,
  output logic               o_push_ready,
  input  ifu_pkg::fq_entry_t i_push_entry,
  output logic               o_pop_valid,
  input  logic               i_pop_ready,
  output ifu_pkg::fq_entry_t o_pop_entry
);

  ifu_pkg::fq_entry_t                entries [ifu_pkg::FQ_DEPTH];

  logic [ifu_pkg::FQ_PTR_WIDTH-1:0]  wr_ptr_q;
  logic [ifu_pkg::FQ_PTR_WIDTH-1:0]  rd_ptr_q;
  logic [ifu_pkg::FQ_CNT_WIDTH-1:0]  count_q;
  logic                              do_push;
  logic                              do_pop;

  assign o_push_ready = (count_q != ifu_pkg::FQ_CNT_WIDTH'(ifu_pkg::FQ_DEPTH));
  assign o_pop_valid  = (count_q != '0);
  assign o_pop_entry  = entries[rd_ptr_q];

  // Flush wins over anything that moves this cycle
  assign do_push = i_push_valid & o_push_ready & ~i_flush;
  assign do_pop  = o_pop_valid & i_pop_ready & ~i_flush;

  always_ff @(posedge i_aclk) begin
    if (do_push) begin
      entries[wr_ptr_q] <= i_push_entry;
    end
  end

  // Depth is a power of two so pointers wrap on their own
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (i_flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== src/ifu_fetch.sv ====
// PC generator and AXI-lite read master with stale response dropping on redirect
`timescale 1ns/1ps

module ifu_fetch (
  input  logic                           i_aclk,
  input  logic                           i_rst_n,
  input  logic                           i_fetch_en,
  axil_rd_if.master                      rd,
  output logic                           o_push_valid,
  input  logic                           i_push_ready,
  output ifu_pkg::fq_entry_t             o_push_entry,
  input  logic                           i_redirect_valid,
  input  logic [ifu_pkg::ADDR_WIDTH-1:0] i_redirect_target
);

  logic [ifu_pkg::ADDR_WIDTH-1:0] pc_q;
  logic [ifu_pkg::ADDR_WIDTH-1:0] req_pc_q;
  logic                           out_q;
  logic                           drop_q;
  logic                           ar_fire;
  logic                           r_fire;
  logic [ifu_pkg::INST_WIDTH-1:0] inst_sel;

  // --------------------------------------------------------------------------
  // Request side
  // --------------------------------------------------------------------------
  // The SRAM is idle whenever nothing is outstanding, so AR never waits
  assign rd.arvalid = i_fetch_en & ~out_q;
  assign rd.araddr  = {pc_q[ifu_pkg::ADDR_WIDTH-1:ifu_pkg::MEM_IDX_LSB],
                       {ifu_pkg::MEM_IDX_LSB{1'b0}}};
  assign rd.arprot  = ifu_pkg::PROT_INST;

  assign ar_fire = rd.arvalid & rd.arready;
  assign r_fire  = rd.rvalid & rd.rready;

  // Queue back-pressure holds the R channel
  assign rd.rready = i_push_ready;

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      out_q <= 1'b0;
    end else if (ar_fire) begin
      out_q <= 1'b1;
    end else if (r_fire) begin
      out_q <= 1'b0;
    end
  end

  // PC of the read in flight
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      req_pc_q <= pc_q;
    end
  end

  // A redirect turns the read in flight stale
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      drop_q <= 1'b0;
    end else if (i_redirect_valid && (ar_fire || (out_q && !r_fire))) begin
      drop_q <= 1'b1;
    end else if (r_fire) begin
      drop_q <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // PC update
  // --------------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q <= ifu_pkg::RESET_PC;
    end else if (i_redirect_valid) begin
      pc_q <= i_redirect_target;
    end else if (r_fire && !drop_q) begin
      pc_q <= req_pc_q + ifu_pkg::ADDR_WIDTH'(4);
    end
  end

  // Upper or lower half of the 64-bit word
  assign inst_sel = req_pc_q[2] ? rd.rdata[ifu_pkg::DATA_WIDTH-1 -: ifu_pkg::INST_WIDTH]
                                : rd.rdata[ifu_pkg::INST_WIDTH-1:0];

  assign o_push_valid      = rd.rvalid & ~drop_q;
  assign o_push_entry.pc   = req_pc_q;
  assign o_push_entry.inst = inst_sel;

endmodule

// ==== src/ifu_pkg.sv ====
// Shared widths, memory geometry, reset PC, AXI codes and fetch queue entry type
package ifu_pkg;

  // --------------------------------------------------------------------------
  // AXI-lite bus widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 64;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int PROT_WIDTH = 3;
  localparam int RESP_WIDTH = 2;
  localparam int INST_WIDTH = 32;

  // Memory geometry, one 64-bit word per index
  localparam int MEM_WORDS     = 1024;
  localparam int MEM_IDX_WIDTH = $clog2(MEM_WORDS);
  localparam int MEM_IDX_LSB   = $clog2(STRB_WIDTH);

  // Fetch queue sizing
  localparam int FQ_DEPTH     = 4;
  localparam int FQ_PTR_WIDTH = $clog2(FQ_DEPTH);
  localparam int FQ_CNT_WIDTH = $clog2(FQ_DEPTH + 1);

  // --------------------------------------------------------------------------
  localparam logic [ADDR_WIDTH-1:0] RESET_PC  = '0;
  localparam logic [RESP_WIDTH-1:0] RESP_OKAY = 2'b00;

  // Unprivileged, secure, instruction access
  localparam logic [PROT_WIDTH-1:0] PROT_INST = 3'b100;

  localparam logic [6:0] OPC_JAL = 7'b1101111;

  // Read channel FSM of the SRAM
  typedef enum logic {
    RD_IDLE = 1'b0,
    RD_READ = 1'b1
  } rd_state_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] pc;
    logic [INST_WIDTH-1:0] inst;
  } fq_entry_t;

endpackage

// ==== src/ifu_top.sv ====
// Fetch front end top level with SRAM, fetch unit, queue and predecoder
`timescale 1ns/1ps

module ifu_top (
  input  logic                           i_aclk,
  input  logic                           i_rst_n,
  input  logic                           i_fetch_en,

  // Program load, AXI-lite write channels
  input  logic                           i_awvalid,
  output logic                           o_awready,
  input  logic [ifu_pkg::ADDR_WIDTH-1:0] i_awaddr,
  input  logic [ifu_pkg::PROT_WIDTH-1:0] i_awprot,
  input  logic                           i_wvalid,
  output logic                           o_wready,
  input  logic [ifu_pkg::DATA_WIDTH-1:0] i_wdata,
  input  logic [ifu_pkg::STRB_WIDTH-1:0] i_wstrb,
  output logic                           o_bvalid,
  input  logic                           i_bready,
  output logic [ifu_pkg::RESP_WIDTH-1:0] o_bresp,

  // Instruction output
  output logic                           o_inst_valid,
  input  logic                           i_inst_ready,
  output logic [ifu_pkg::ADDR_WIDTH-1:0] o_inst_pc,
  output logic [ifu_pkg::INST_WIDTH-1:0] o_inst
);

  axil_rd_if u_rd_if ();
  axil_wr_if u_wr_if ();

  logic                           push_valid;
  logic                           push_ready;
  ifu_pkg::fq_entry_t             push_entry;
  logic                           pop_valid;
  logic                           pop_ready;
  ifu_pkg::fq_entry_t             pop_entry;
  logic                           redirect_valid;
  logic [ifu_pkg::ADDR_WIDTH-1:0] redirect_target;

  // --------------------------------------------------------------------------
  // Write channel bundling
  // --------------------------------------------------------------------------
  assign u_wr_if.awvalid = i_awvalid;
  assign u_wr_if.awaddr  = i_awaddr;
  assign u_wr_if.awprot  = i_awprot;
  assign u_wr_if.wvalid  = i_wvalid;
  assign u_wr_if.wdata   = i_wdata;
  assign u_wr_if.wstrb   = i_wstrb;
  assign u_wr_if.bready  = i_bready;
  assign o_awready       = u_wr_if.awready;
  assign o_wready        = u_wr_if.wready;
  assign o_bvalid        = u_wr_if.bvalid;
  assign o_bresp         = u_wr_if.bresp;

  // --------------------------------------------------------------------------
  // Blocks
  // --------------------------------------------------------------------------
  axil_inst_sram u_sram (
    .i_aclk  (i_aclk),
    .i_rst_n (i_rst_n),
    .rd      (u_rd_if),
    .wr      (u_wr_if)
  );

  ifu_fetch u_fetch (
    .i_aclk            (i_aclk),
    .i_rst_n           (i_rst_n),
    .i_fetch_en        (i_fetch_en),
    .rd                (u_rd_if),
    .o_push_valid      (push_valid),
    .i_push_ready      (push_ready),
    .o_push_entry      (push_entry),
    .i_redirect_valid  (redirect_valid),
    .i_redirect_target (redirect_target)
  );

  // Redirect also flushes everything fetched past the JAL
  fetch_queue u_queue (
    .i_aclk       (i_aclk),
    .i_rst_n      (i_rst_n),
    .i_flush      (redirect_valid),
    .i_push_valid (push_valid),
    .o_push_ready (push_ready),
    .i_push_entry (push_entry),
    .o_pop_valid  (pop_valid),
    .i_pop_ready  (pop_ready),
    .o_pop_entry  (pop_entry)
  );

  inst_predecode u_predecode (
    .i_pop_valid       (pop_valid),
    .o_pop_ready       (pop_ready),
    .i_pop_entry       (pop_entry),
    .o_inst_valid      (o_inst_valid),
    .i_inst_ready      (i_inst_ready),
    .o_inst_pc         (o_inst_pc),
    .o_inst            (o_inst),
    .o_redirect_valid  (redirect_valid),
    .o_redirect_target (redirect_target)
  );

endmodule

// ==== src/inst_predecode.sv ====
// Output stage that hands out instructions and redirects fetch on JAL
`timescale 1ns/1ps

module inst_predecode (
  input  logic                           i_pop_valid,
  output logic                           o_pop_ready,
  input  ifu_pkg::fq_entry_t             i_pop_entry,
  output logic                           o_inst_valid,
  input  logic                           i_inst_ready,
  output logic [ifu_pkg::ADDR_WIDTH-1:0] o_inst_pc,
  output logic [ifu_pkg::INST_WIDTH-1:0] o_inst,
  output logic                           o_redirect_valid,
  output logic [ifu_pkg::ADDR_WIDTH-1:0] o_redirect_target
);

  logic [ifu_pkg::INST_WIDTH-1:0] inst;
  logic                           is_jal;
  logic                           out_fire;
  logic [ifu_pkg::ADDR_WIDTH-1:0] j_imm;

  assign inst = i_pop_entry.inst;

  // --------------------------------------------------------------------------
  // Handshake to the core side
  // --------------------------------------------------------------------------
  assign o_inst_valid = i_pop_valid;
  assign o_pop_ready  = i_inst_ready;
  assign o_inst_pc    = i_pop_entry.pc;
  assign o_inst       = inst;

  assign out_fire = i_pop_valid & i_inst_ready;

  // --------------------------------------------------------------------------
  // JAL detect and target
  // --------------------------------------------------------------------------
  assign is_jal = (inst[6:0] == ifu_pkg::OPC_JAL);

  // J-type immediate, imm[20|10:1|11|19:12], bit 0 always zero
  assign j_imm = {{(ifu_pkg::ADDR_WIDTH-21){inst[31]}},
                  inst[31],
                  inst[19:12],
                  inst[20],
                  inst[30:21],
                  1'b0};

  // Queue flush on this pulse empties the head, so it lasts one cycle
  assign o_redirect_valid  = out_fire & is_jal;
  assign o_redirect_target = i_pop_entry.pc + j_imm;

endmodule

// ==== verif/tb_ifu_model.svh ====
// LCG, reference memory image, JAL encoder and PC walk model for the fetch testbench
`ifndef TB_IFU_MODEL_SVH
`define TB_IFU_MODEL_SVH

logic [31:0]                    lcg_state = 32'hc442bd59;
logic [ifu_pkg::DATA_WIDTH-1:0] model_mem [ifu_pkg::MEM_WORDS];

// Numerical Recipes constants
function automatic logic [31:0] next_random();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// Low LCG bits are weak, so take the upper ones
function automatic int unsigned random_below(input int unsigned n);
  logic [31:0] r;
  r = next_random();
  return (r >> 8) % n;
endfunction

function automatic logic [31:0] make_jal(input logic [20:0] off, input logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, ifu_pkg::OPC_JAL};
endfunction

function automatic void merge_write(input int unsigned idx, input logic [63:0] data,
                                    input logic [7:0] strb);
  for (int b = 0; b < 8; b++) begin
    if (strb[b]) begin
      model_mem[idx][8*b +: 8] = data[8*b +: 8];
    end
  end
endfunction

// Memory wraps on the index bits, bit 2 picks the half
function automatic logic [31:0] inst_at(input logic [31:0] pc);
  logic [63:0] word;
  word = model_mem[pc[ifu_pkg::MEM_IDX_LSB +: ifu_pkg::MEM_IDX_WIDTH]];
  return pc[2] ? word[63:32] : word[31:0];
endfunction

function automatic logic [31:0] next_pc(input logic [31:0] pc);
  logic [31:0] inst;
  inst = inst_at(pc);
  if (inst[6:0] == ifu_pkg::OPC_JAL) begin
    return pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  end
  return pc + 32'd4;
endfunction

`endif

// ==== verif/tb_ifu_top.sv ====
// Fetch front end testbench with program load, strobed rewrites and walk checks
`timescale 1ns/1ps

module tb_ifu_top;

  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 4;
  localparam int STROBE_WORDS   = 32;
  localparam int STROBE_RANGE   = 256;
  localparam int LOAD_WRITES    = ifu_pkg::MEM_WORDS + STROBE_WORDS;
  localparam int FETCH_COUNT    = 400;
  localparam int TIMEOUT_CYCLES = LOAD_WRITES * 4 + FETCH_COUNT * 12 + 1000;

  logic                           i_aclk;
  logic                           i_rst_n;
  logic                           i_fetch_en;
  logic                           i_awvalid;
  logic                           o_awready;
  logic [ifu_pkg::ADDR_WIDTH-1:0] i_awaddr;
  logic [ifu_pkg::PROT_WIDTH-1:0] i_awprot;
  logic                           i_wvalid;
  logic                           o_wready;
  logic [ifu_pkg::DATA_WIDTH-1:0] i_wdata;
  logic [ifu_pkg::STRB_WIDTH-1:0] i_wstrb;
  logic                           o_bvalid;
  logic                           i_bready;
  logic [ifu_pkg::RESP_WIDTH-1:0] o_bresp;
  logic                           o_inst_valid;
  logic                           i_inst_ready;
  logic [ifu_pkg::ADDR_WIDTH-1:0] o_inst_pc;
  logic [ifu_pkg::INST_WIDTH-1:0] o_inst;
  int                             cycle_count = 0;
  bit                             touched [ifu_pkg::MEM_WORDS];

  `include "tb_ifu_model.svh"

  ifu_top u_dut (.*);

  always #(CLK_PERIOD / 2) i_aclk = ~i_aclk;

  // Hang guard
  always @(posedge i_aclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // AW and W raised at random, each held until its own transfer
  task automatic axi_write(input logic [31:0] addr, input logic [63:0] data,
                           input logic [7:0] strb);
    bit aw_done;
    bit w_done;
    bit b_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    b_done  = 1'b0;
    while (!b_done) begin
      @(negedge i_aclk);
      if (aw_done) begin
        i_awvalid = 1'b0;
      end else if (!i_awvalid && random_below(8) != 0) begin
        i_awvalid = 1'b1;
        i_awaddr  = addr;
      end
      if (w_done) begin
        i_wvalid = 1'b0;
      end else if (!i_wvalid && random_below(8) != 0) begin
        i_wvalid = 1'b1;
        i_wdata  = data;
        i_wstrb  = strb;
      end
      i_bready = (random_below(4) != 0);
      @(posedge i_aclk);
      if (i_awvalid && o_awready) aw_done = 1'b1;
      if (i_wvalid && o_wready) w_done = 1'b1;
      if (o_bvalid && i_bready) begin
        check_value("write_bresp", ifu_pkg::RESP_OKAY, o_bresp);
        b_done = 1'b1;
      end
    end
  endtask

  // About one half in eight becomes a short forward JAL
  task automatic build_program();
    logic [31:0] half;
    for (int w = 0; w < ifu_pkg::MEM_WORDS; w++) begin
      for (int h = 0; h < 2; h++) begin
        half = next_random();
        if (random_below(8) == 0) begin
          half = make_jal(21'((random_below(16) + 1) * 4), half[11:7]);
        end else if (half[6:0] == ifu_pkg::OPC_JAL) begin
          half[3] = 1'b0;
        end
        model_mem[w][32*h +: 32] = half;
      end
    end
    for (int w = 0; w < ifu_pkg::MEM_WORDS; w++) begin
      axi_write(32'(w) << ifu_pkg::MEM_IDX_LSB, model_mem[w], 8'hff);
    end
  endtask

  task automatic rewrite_strobed();
    int unsigned idx;
    logic [63:0] data;
    logic [7:0]  strb;
    for (int i = 0; i < STROBE_WORDS; i++) begin
      idx          = random_below(STROBE_RANGE);
      data[31:0]   = next_random();
      data[63:32]  = next_random();
      strb         = 8'(random_below(256));
      if (strb == 8'hff || strb == 8'h00) strb = 8'h5a;
      axi_write(32'(idx) << ifu_pkg::MEM_IDX_LSB, data, strb);
      merge_write(idx, data, strb);
      touched[idx] = 1'b1;
    end
  endtask

  // Consumer ready is high 60 percent of cycles
  task automatic run_fetch();
    logic [31:0] exp_pc;
    int          seen;
    int          jal_seen;
    int          strobe_hits;
    bit          after_jal;
    exp_pc      = ifu_pkg::RESET_PC;
    seen        = 0;
    jal_seen    = 0;
    strobe_hits = 0;
    after_jal   = 1'b0;
    @(negedge i_aclk);
    i_fetch_en = 1'b1;
    while (seen < FETCH_COUNT) begin
      @(negedge i_aclk);
      i_inst_ready = (random_below(10) < 6);
      @(posedge i_aclk);
      if (o_inst_valid && i_inst_ready) begin
        check_value(after_jal ? "jal_target" : "fetch_pc", exp_pc, o_inst_pc);
        check_value("fetch_inst", inst_at(exp_pc), o_inst);
        after_jal = (o_inst[6:0] == ifu_pkg::OPC_JAL);
        if (after_jal) jal_seen++;
        if (touched[exp_pc[ifu_pkg::MEM_IDX_LSB +: ifu_pkg::MEM_IDX_WIDTH]]) strobe_hits++;
        exp_pc = next_pc(exp_pc);
        seen++;
      end
    end
    check_value("jal_coverage", 64'd1, 64'(jal_seen > 0));
    check_value("strobe_coverage", 64'd1, 64'(strobe_hits > 0));
  endtask

  initial begin
    i_aclk       = 1'b0;
    i_rst_n      = 1'b0;
    i_fetch_en   = 1'b0;
    i_awvalid    = 1'b0;
    i_awaddr     = '0;
    i_awprot     = '0;
    i_wvalid     = 1'b0;
    i_wdata      = '0;
    i_wstrb      = '0;
    i_bready     = 1'b0;
    i_inst_ready = 1'b0;
    repeat (RESET_CYCLES) @(posedge i_aclk);
    @(negedge i_aclk);
    i_rst_n = 1'b1;
    check_value("reset_inst_valid", 64'd0, 64'(o_inst_valid));
    check_value("reset_bvalid", 64'd0, 64'(o_bvalid));
    check_value("reset_awready", 64'd0, 64'(o_awready));
    check_value("reset_wready", 64'd0, 64'(o_wready));
    build_program();
    rewrite_strobed();
    run_fetch();
    $display("TEST PASS");
    $finish;
  end

endmodule
